//--- Makefile
# Verilator flow for the maintenance snoop queue
TOP = tb_ctcq

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
	  --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- ctcq_ctrl.sv
//********************
// create, launch and response pointers
// launch state machine
//********************
`include "ctcq_params.svh"

module ctcq_ctrl (
  input  logic          ctcq_pe_clk,
  input  logic          cpurst_b,
  input  logic          create_en,
  output logic          create_rdy,
  output logic          cr_valid,
  input  logic          cr_ready,
  output logic          ctcq_not_empty,
  ctcq_entry_if.ctrl    ent,
  ctcq_launch_if.ctrl   lau
);
  import ctcq_pkg::*;

  logic [`CTCQ_DEPTH-1:0] create_ptr_q;
  logic [`CTCQ_DEPTH-1:0] launch_ptr_q;
  logic [`CTCQ_DEPTH-1:0] resp_ptr_q;
  launch_state_e          state_q;
  logic                   launch_pend;

  // rotate a one-hot pointer by one entry
  function automatic logic [`CTCQ_DEPTH-1:0] rotl(input logic [`CTCQ_DEPTH-1:0] ptr);
    return {ptr[`CTCQ_DEPTH-2:0], ptr[`CTCQ_DEPTH-1]};
  endfunction

  //********************
  // handshakes
  //********************
  assign create_rdy     = |(create_ptr_q & ent.entry_free);
  assign cr_valid       = |(resp_ptr_q & ent.entry_done);
  assign ctcq_not_empty = ~&ent.entry_free;

  assign launch_pend     = |(launch_ptr_q & ent.entry_pend);
  assign ent.create_fire = create_en && create_rdy;
  assign ent.issue_fire  = (state_q == LAUNCH_IDLE) && launch_pend;
  assign ent.cmplt_fire  = lau.done_fire;
  assign ent.free_fire   = cr_valid && cr_ready;

  assign ent.create_ptr = create_ptr_q;
  assign ent.launch_ptr = launch_ptr_q;
  assign ent.resp_ptr   = resp_ptr_q;

  // launcher takes the entry at launch_ptr
  assign lau.load    = ent.issue_fire;
  assign lau.payload = ent.launch_entry;

  //********************
  // pointers
  //********************
  always_ff @(posedge ctcq_pe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      create_ptr_q <= `CTCQ_DEPTH'(1);
      launch_ptr_q <= `CTCQ_DEPTH'(1);
      resp_ptr_q   <= `CTCQ_DEPTH'(1);
    end
    else
    begin
      if (ent.create_fire)
        create_ptr_q <= rotl(create_ptr_q);
      // launch_ptr moves on completion, not on issue
      if (ent.cmplt_fire)
        launch_ptr_q <= rotl(launch_ptr_q);
      if (ent.free_fire)
        resp_ptr_q <= rotl(resp_ptr_q);
    end
  end

  //********************
  // launch FSM
  //********************
  always_ff @(posedge ctcq_pe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state_q <= LAUNCH_IDLE;
    else
    begin
      case (state_q)
        LAUNCH_IDLE:
          if (ent.issue_fire)
            state_q <= LAUNCH_WAIT;
        LAUNCH_WAIT:
          if (lau.done_fire)
            state_q <= LAUNCH_IDLE;
        default:
          state_q <= LAUNCH_IDLE;
      endcase
    end
  end

  // arbiter must wait for a free entry
  a_create_when_rdy: assert property (
    @(posedge ctcq_pe_clk) disable iff (!cpurst_b)
    create_en |-> create_rdy
  );

  // FSM and launcher busy flag stay in step
  a_no_load_busy: assert property (
    @(posedge ctcq_pe_clk) disable iff (!cpurst_b)
    lau.load |-> !lau.busy
  );

endmodule

//--- ctcq_entry_array.sv
//********************
// six entry state registers and payloads
// launch entry selection
//********************
`include "ctcq_params.svh"

module ctcq_entry_array (
  input  logic                        ctcq_pe_clk,
  input  logic                        cpurst_b,
  input  logic [`CTC_OP_W-1:0]        ctc_type,
  input  logic [`CTCQ_ASID_IN_W-1:0]  ctc_asid_va,
  input  logic [`CTCQ_VAPA_W-1:0]     ctc_va_pa,
  ctcq_entry_if.array                 ent
);
  import ctcq_pkg::*;

  entry_state_e state_q   [`CTCQ_DEPTH];
  ctcq_entry_t  payload_q [`CTCQ_DEPTH];
  ctcq_entry_t  create_entry;

  //********************
  // create payload
  //********************
  // asid keeps raw bits 23-16 and 7-0
  assign create_entry.op    = ctc_op_e'(ctc_type);
  assign create_entry.asid  = {ctc_asid_va[`CTCQ_ASID_IN_W-1:`CTCQ_ASID_IN_W-8],
                               ctc_asid_va[7:0]};
  assign create_entry.va_pa = ctc_va_pa;

  always_ff @(posedge ctcq_pe_clk)
  begin
    for (int i = 0; i < `CTCQ_DEPTH; i++)
    begin
      if (ent.create_fire && ent.create_ptr[i])
        payload_q[i] <= create_entry;
    end
  end

  //********************
  // entry states
  //********************
  // free -> pend -> issued -> done -> free
  always_ff @(posedge ctcq_pe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      for (int i = 0; i < `CTCQ_DEPTH; i++)
        state_q[i] <= ENTRY_FREE;
    end
    else
    begin
      for (int i = 0; i < `CTCQ_DEPTH; i++)
      begin
        if (ent.create_fire && ent.create_ptr[i])
          state_q[i] <= ENTRY_PEND;
        else if (ent.issue_fire && ent.launch_ptr[i])
          state_q[i] <= ENTRY_ISSUED;
        else if (ent.cmplt_fire && ent.launch_ptr[i])
          state_q[i] <= ENTRY_DONE;
        else if (ent.free_fire && ent.resp_ptr[i])
          state_q[i] <= ENTRY_FREE;
      end
    end
  end

  always_comb
  begin
    for (int i = 0; i < `CTCQ_DEPTH; i++)
    begin
      ent.entry_pend[i] = (state_q[i] == ENTRY_PEND);
      ent.entry_done[i] = (state_q[i] == ENTRY_DONE);
      ent.entry_free[i] = (state_q[i] == ENTRY_FREE);
    end
  end

  // one-hot mux at launch_ptr
  always_comb
  begin
    ent.launch_entry = payload_q[0];
    for (int i = 1; i < `CTCQ_DEPTH; i++)
    begin
      if (ent.launch_ptr[i])
        ent.launch_entry = payload_q[i];
    end
  end

  // a created entry must carry an opcode the launcher can decode
  a_create_op_legal: assert property (
    @(posedge ctcq_pe_clk) disable iff (!cpurst_b)
    ent.create_fire |-> (ctc_type <= TLB_VA_ASID)
  );

endmodule

//--- ctcq_entry_if.sv
//********************
// control to entry array connection
//********************
`include "ctcq_params.svh"

interface ctcq_entry_if;
  import ctcq_pkg::*;

  // one-hot pointers
  logic [`CTCQ_DEPTH-1:0] create_ptr;
  logic [`CTCQ_DEPTH-1:0] launch_ptr;
  logic [`CTCQ_DEPTH-1:0] resp_ptr;

  // single-cycle state change strobes
  logic                   create_fire;
  logic                   issue_fire;
  logic                   cmplt_fire;
  logic                   free_fire;

  // per-entry state flags
  logic [`CTCQ_DEPTH-1:0] entry_pend;
  logic [`CTCQ_DEPTH-1:0] entry_done;
  logic [`CTCQ_DEPTH-1:0] entry_free;

  // payload selected by launch_ptr
  ctcq_entry_t            launch_entry;

  modport ctrl (
    output create_ptr, launch_ptr, resp_ptr,
    output create_fire, issue_fire, cmplt_fire, free_fire,
    input  entry_pend, entry_done, entry_free, launch_entry
  );

  modport array (
    input  create_ptr, launch_ptr, resp_ptr,
    input  create_fire, issue_fire, cmplt_fire, free_fire,
    output entry_pend, entry_done, entry_free, launch_entry
  );

endinterface

//--- ctcq_input.txt
// columns: op  asid_va (24 bits)  va_pa (36 bits, address 39..4)  flush_dis
// op: 0 icache all, 1 icache line, 2 tlb all, 3 tlb va, 4 tlb asid, 5 tlb va and asid
1 3a00c5 0f31c2a87 0
5 1b7742 8a4d61e3c 1
0 000000 000000000 0
3 c40a19 7e2b09d54 0
4 5d3f6e 13579bdf0 1
2 000000 000000000 0
1 9e1177 f0e1d2c3b 1
5 a5a55a 2468ace13 0
3 07f3c0 b4c5d6e7f 1
4 ffff00 00ff00ff0 0
0 123456 fedcba987 1
2 654321 89abcdef0 0
5 0f0f0f 1c3b5a796 0
1 800001 5a5a5a5a5 0
3 3c3c3c 0a1b2c3d4 0
4 e07e01 c0ffee123 1
5 7fff80 9876fedc1 1
2 110022 333444555 1
1 44aa88 ffffffffc 0
0 deadbe 0badf00d7 0
3 25c9e4 6b8e1f27a 1
4 0c0c0c abcabcabc 0
5 ff00ff 3e5f7a9bd 0
1 56e2a3 e4d3c2b1a 1

//--- ctcq_inv_launch.sv
//********************
// registered invalidation request and field decode
// done detection and flush pulse
//********************
`include "ctcq_params.svh"

module ctcq_inv_launch (
  input  logic                       ctcq_pe_clk,
  input  logic                       cpurst_b,
  input  logic                       icache_inv_done,
  input  logic                       tlb_inv_done,
  input  logic                       flush_dis,
  output logic                       icache_all_inv,
  output logic                       icache_line_inv,
  output logic [`ICACHE_IDX_W-1:0]   icache_index,
  output logic [`ICACHE_PTAG_W-1:0]  icache_ptag,
  output logic                       tlb_all_inv,
  output logic                       tlb_va_all_inv,
  output logic                       tlb_asid_all_inv,
  output logic                       tlb_va_asid_inv,
  output logic [`CTCQ_ASID_W-1:0]    tlb_asid,
  output logic [`TLB_VA_W-1:0]       tlb_va,
  output logic                       ctc_flush_vld,
  ctcq_launch_if.launch              lau
);
  import ctcq_pkg::*;

  localparam int INV_KINDS = 6;

  logic                     busy_q;
  logic [INV_KINDS-1:0]     strobe_q;
  logic                     flush_q;
  logic [`CTCQ_VAPA_W-1:0]  va_pa_q;
  logic [`CTCQ_ASID_W-1:0]  asid_q;

  assign lau.busy      = busy_q;
  assign lau.done_fire = busy_q && (icache_inv_done || tlb_inv_done);

  //********************
  // request registers
  //********************
  // one strobe per opcode, held until done
  always_ff @(posedge ctcq_pe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      busy_q   <= 1'b0;
      strobe_q <= '0;
    end
    else if (lau.done_fire)
    begin
      busy_q   <= 1'b0;
      strobe_q <= '0;
    end
    else if (lau.load)
    begin
      busy_q   <= 1'b1;
      strobe_q <= INV_KINDS'(1) << lau.payload.op;
    end
  end

  always_ff @(posedge ctcq_pe_clk)
  begin
    if (lau.load)
    begin
      va_pa_q <= lau.payload.va_pa;
      asid_q  <= lau.payload.asid;
    end
  end

  // pipeline flush one cycle after each completion
  always_ff @(posedge ctcq_pe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      flush_q <= 1'b0;
    else
      flush_q <= lau.done_fire && !flush_dis;
  end

  assign ctc_flush_vld = flush_q;

  //********************
  // outputs
  //********************
  assign icache_all_inv   = strobe_q[ICACHE_ALL];
  assign icache_line_inv  = strobe_q[ICACHE_LINE];
  assign tlb_all_inv      = strobe_q[TLB_ALL];
  assign tlb_va_all_inv   = strobe_q[TLB_VA_ALL];
  assign tlb_asid_all_inv = strobe_q[TLB_ASID_ALL];
  assign tlb_va_asid_inv  = strobe_q[TLB_VA_ASID];

  // va_pa[0] is address bit 4
  assign icache_index = va_pa_q[`ICACHE_IDX_W+1:2];
  assign icache_ptag  = va_pa_q[`ICACHE_PTAG_W+7:8];
  assign tlb_va       = va_pa_q[`TLB_VA_W+7:8];
  assign tlb_asid     = asid_q;

  // done only answers a raised strobe
  a_done_when_busy: assert property (
    @(posedge ctcq_pe_clk) disable iff (!cpurst_b)
    (icache_inv_done || tlb_inv_done) |-> busy_q
  );

endmodule

//--- ctcq_launch_if.sv
//********************
// control to invalidation launcher connection
//********************
interface ctcq_launch_if;
  import ctcq_pkg::*;

  // load the launcher with the oldest pending entry
  logic        load;
  ctcq_entry_t payload;

  // launcher status back to control
  logic        busy;
  logic        done_fire;

  modport ctrl (
    output load, payload,
    input  busy, done_fire
  );

  modport launch (
    input  load, payload,
    output busy, done_fire
  );

endinterface

//--- ctcq_params.svh
//********************
// widths and depth of the maintenance snoop queue
//********************
`ifndef CTCQ_PARAMS_SVH
`define CTCQ_PARAMS_SVH

// number of queue entries
`define CTCQ_DEPTH 6

// request opcode
`define CTC_OP_W 3

// address bits 39 down to 4
`define CTCQ_VAPA_W 36

// raw asid/va field from the arbiter, packed down to 16 bits
`define CTCQ_ASID_IN_W 24
`define CTCQ_ASID_W 16

// invalidation side fields
`define ICACHE_IDX_W 6
`define ICACHE_PTAG_W 28
`define TLB_VA_W 27

`endif

//--- ctcq_pkg.sv
//********************
// opcode, entry state and launch state enums
// stored queue entry struct
//********************
`include "ctcq_params.svh"

package ctcq_pkg;

  // maintenance request kinds, codes 6 and 7 illegal
  typedef enum logic [`CTC_OP_W-1:0] {
    ICACHE_ALL   = 3'd0,
    ICACHE_LINE  = 3'd1,
    TLB_ALL      = 3'd2,
    TLB_VA_ALL   = 3'd3,
    TLB_ASID_ALL = 3'd4,
    TLB_VA_ASID  = 3'd5
  } ctc_op_e;

  // per-entry life cycle
  typedef enum logic [1:0] {
    ENTRY_FREE   = 2'd0,
    ENTRY_PEND   = 2'd1,
    ENTRY_ISSUED = 2'd2,
    ENTRY_DONE   = 2'd3
  } entry_state_e;

  // only one invalidation outstanding at a time
  typedef enum logic {
    LAUNCH_IDLE = 1'b0,
    LAUNCH_WAIT = 1'b1
  } launch_state_e;

  // 55 bits per entry
  typedef struct packed {
    ctc_op_e                  op;
    logic [`CTCQ_ASID_W-1:0]  asid;
    logic [`CTCQ_VAPA_W-1:0]  va_pa;
  } ctcq_entry_t;

endpackage

//--- ctcq_top.sv
//********************
// maintenance snoop queue top level
//********************
`include "ctcq_params.svh"

module ctcq_top (
  input  logic                        ctcq_pe_clk,
  input  logic                        cpurst_b,
  // create side
  input  logic                        create_en,
  input  logic [`CTC_OP_W-1:0]        ctc_type,
  input  logic [`CTCQ_ASID_IN_W-1:0]  ctc_asid_va,
  input  logic [`CTCQ_VAPA_W-1:0]     ctc_va_pa,
  output logic                        create_rdy,
  // invalidation side
  output logic                        icache_all_inv,
  output logic                        icache_line_inv,
  output logic [`ICACHE_IDX_W-1:0]    icache_index,
  output logic [`ICACHE_PTAG_W-1:0]   icache_ptag,
  output logic                        tlb_all_inv,
  output logic                        tlb_va_all_inv,
  output logic                        tlb_asid_all_inv,
  output logic                        tlb_va_asid_inv,
  output logic [`CTCQ_ASID_W-1:0]     tlb_asid,
  output logic [`TLB_VA_W-1:0]        tlb_va,
  input  logic                        icache_inv_done,
  input  logic                        tlb_inv_done,
  // response side
  output logic                        cr_valid,
  input  logic                        cr_ready,
  // other
  input  logic                        flush_dis,
  output logic                        ctc_flush_vld,
  output logic                        ctcq_not_empty
);

  ctcq_entry_if  ent_if ();
  ctcq_launch_if lau_if ();

  ctcq_ctrl u_ctrl (
    .ctcq_pe_clk    (ctcq_pe_clk),
    .cpurst_b       (cpurst_b),
    .create_en      (create_en),
    .create_rdy     (create_rdy),
    .cr_valid       (cr_valid),
    .cr_ready       (cr_ready),
    .ctcq_not_empty (ctcq_not_empty),
    .ent            (ent_if.ctrl),
    .lau            (lau_if.ctrl)
  );

  // create payload goes straight into the entries
  ctcq_entry_array u_entry_array (
    .ctcq_pe_clk (ctcq_pe_clk),
    .cpurst_b    (cpurst_b),
    .ctc_type    (ctc_type),
    .ctc_asid_va (ctc_asid_va),
    .ctc_va_pa   (ctc_va_pa),
    .ent         (ent_if.array)
  );

  ctcq_inv_launch u_inv_launch (
    .ctcq_pe_clk      (ctcq_pe_clk),
    .cpurst_b         (cpurst_b),
    .icache_inv_done  (icache_inv_done),
    .tlb_inv_done     (tlb_inv_done),
    .flush_dis        (flush_dis),
    .icache_all_inv   (icache_all_inv),
    .icache_line_inv  (icache_line_inv),
    .icache_index     (icache_index),
    .icache_ptag      (icache_ptag),
    .tlb_all_inv      (tlb_all_inv),
    .tlb_va_all_inv   (tlb_va_all_inv),
    .tlb_asid_all_inv (tlb_asid_all_inv),
    .tlb_va_asid_inv  (tlb_va_asid_inv),
    .tlb_asid         (tlb_asid),
    .tlb_va           (tlb_va),
    .ctc_flush_vld    (ctc_flush_vld),
    .lau              (lau_if.launch)
  );

endmodule

//--- project.f
+incdir+.
ctcq_pkg.sv
ctcq_entry_if.sv
ctcq_launch_if.sv
ctcq_entry_array.sv
ctcq_ctrl.sv
ctcq_inv_launch.sv
ctcq_top.sv
tb_ctcq.sv

//--- tb_ctcq.sv
//********************
// self-checking testbench for the snoop queue
// invalidation and response models, scoreboard
//********************
`include "ctcq_params.svh"

module tb_ctcq;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_REQ = 24;
  localparam int MAX_CYC = NUM_REQ * 40 + 200;

  logic                        ctcq_pe_clk;
  logic                        cpurst_b;
  logic                        create_en;
  logic [`CTC_OP_W-1:0]        ctc_type;
  logic [`CTCQ_ASID_IN_W-1:0]  ctc_asid_va;
  logic [`CTCQ_VAPA_W-1:0]     ctc_va_pa;
  logic                        create_rdy;
  logic                        icache_all_inv;
  logic                        icache_line_inv;
  logic [`ICACHE_IDX_W-1:0]    icache_index;
  logic [`ICACHE_PTAG_W-1:0]   icache_ptag;
  logic                        tlb_all_inv;
  logic                        tlb_va_all_inv;
  logic                        tlb_asid_all_inv;
  logic                        tlb_va_asid_inv;
  logic [`CTCQ_ASID_W-1:0]     tlb_asid;
  logic [`TLB_VA_W-1:0]        tlb_va;
  logic                        icache_inv_done;
  logic                        tlb_inv_done;
  logic                        cr_valid;
  logic                        cr_ready;
  logic                        flush_dis;
  logic                        ctc_flush_vld;
  logic                        ctcq_not_empty;

  // four words per request: op, asid_va, va_pa, flush_dis
  logic [35:0]                 stim_mem [NUM_REQ*4];
  logic [`CTC_OP_W-1:0]        req_op [NUM_REQ];
  logic [`CTCQ_ASID_IN_W-1:0]  req_asid_va [NUM_REQ];
  logic [`CTCQ_VAPA_W-1:0]     req_vapa [NUM_REQ];
  logic                        req_flush [NUM_REQ];
  logic [5:0]                  strb;
  logic [5:0]                  prev_strb;

  int launch_q[$];
  int errors;
  int cycles;
  int next_req;
  int taken_cnt;
  int cmplt_cnt;
  int xfer_cnt;
  int flush_cnt;
  int flush_exp_cnt;
  int done_wait;
  int low_stretch;
  bit done_armed;
  bit hold_done;
  bit done_drv;
  bit prev_done_drv;
  bit prev_flush_dis;
  bit prev_create;
  bit prev_cr_valid;
  bit prev_cr_ready;
  bit timed_out;

  assign strb = {tlb_va_asid_inv, tlb_asid_all_inv, tlb_va_all_inv,
                 tlb_all_inv, icache_line_inv, icache_all_inv};

  ctcq_top dut_i (.*);

  always
  begin
    #20 ctcq_pe_clk = ~ctcq_pe_clk;
  end

  task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string msg);
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH at %0d ns: %s got %0h expected %0h", $time, msg, got, exp);
    end
  endtask

  //********************
  // input driving, 2 ns after the edge
  //********************
  task automatic drive_cycle();
    int r;
    prev_done_drv  = done_drv;
    prev_flush_dis = flush_dis;
    prev_create    = create_en;
    // head request retires once its done has been sampled
    if (prev_done_drv && launch_q.size() > 0)
    begin
      if (!req_flush[launch_q[0]])
        flush_exp_cnt++;
      void'(launch_q.pop_front());
    end
    if (next_req < NUM_REQ && create_rdy)
    begin
      create_en   = 1'b1;
      ctc_type    = req_op[next_req];
      ctc_asid_va = req_asid_va[next_req];
      ctc_va_pa   = req_vapa[next_req];
      launch_q.push_back(next_req);
      next_req++;
    end
    else
    begin
      create_en   = 1'b0;
      ctc_type    = '0;
      ctc_asid_va = '0;
      ctc_va_pa   = '0;
    end
    // flush_dis follows the oldest outstanding request
    flush_dis = (launch_q.size() > 0) ? req_flush[launch_q[0]] : 1'b0;
    done_drv  = 1'b0;
    if (strb != '0)
    begin
      if (!done_armed)
      begin
        done_armed = 1'b1;
        done_wait  = $urandom_range(3, 0);
      end
      if (!hold_done)
      begin
        if (done_wait > 0)
          done_wait--;
        else
        begin
          done_drv   = 1'b1;
          done_armed = 1'b0;
        end
      end
    end
    icache_inv_done = done_drv && (icache_all_inv || icache_line_inv);
    tlb_inv_done    = done_drv && !(icache_all_inv || icache_line_inv);
    // response ready with occasional low stretches
    if (low_stretch > 0)
    begin
      cr_ready = 1'b0;
      low_stretch--;
    end
    else
    begin
      r = $urandom_range(7, 0);
      if (r == 0)
      begin
        low_stretch = $urandom_range(5, 2);
        cr_ready    = 1'b0;
      end
      else
        cr_ready = (r > 2);
    end
  endtask

  //********************
  // mid-cycle checks
  //********************
  task automatic check_cycle();
    int head;
    if (prev_create)
      taken_cnt++;
    if (prev_done_drv)
    begin
      cmplt_cnt++;
      check_val(64'(strb), 64'(0), "strobe after done");
    end
    else if (prev_strb != '0)
      check_val(64'(strb), 64'(prev_strb), "strobe changed before done");
    else if (strb != '0)
    begin
      if (launch_q.size() == 0)
      begin
        errors++;
        $display("strobe raised with no request outstanding at %0d ns", $time);
      end
      else
      begin
        head = launch_q[0];
        check_val(64'(strb), 64'(6'(1) << req_op[head]), "strobe kind");
        check_val(64'(icache_index), 64'(req_vapa[head][7:2]), "icache_index");
        check_val(64'(icache_ptag), 64'(req_vapa[head][35:8]), "icache_ptag");
        check_val(64'(tlb_va), 64'(req_vapa[head][34:8]), "tlb_va");
        check_val(64'(tlb_asid),
                  64'({req_asid_va[head][23:16], req_asid_va[head][7:0]}), "tlb_asid");
      end
    end
    check_val(64'(ctc_flush_vld), 64'(prev_done_drv && !prev_flush_dis), "ctc_flush_vld");
    if (ctc_flush_vld)
      flush_cnt++;
    if (prev_cr_valid && !prev_cr_ready)
      check_val(64'(cr_valid), 64'(1), "cr_valid held without cr_ready");
    if (cr_valid && cr_ready)
      xfer_cnt++;
    check_val(64'(xfer_cnt > cmplt_cnt), 64'(0), "transfers ahead of completions");
    // six entries occupied while done is withheld
    if (hold_done && taken_cnt == `CTCQ_DEPTH)
    begin
      check_val(64'(create_rdy), 64'(0), "create_rdy with full queue");
      check_val(64'(ctcq_not_empty), 64'(1), "ctcq_not_empty with full queue");
      hold_done = 1'b0;
    end
    prev_strb     = strb;
    prev_cr_valid = cr_valid;
    prev_cr_ready = cr_ready;
  endtask

  initial
  begin
    ctcq_pe_clk     = 1'b0;
    cpurst_b        = 1'b0;
    create_en       = 1'b0;
    ctc_type        = '0;
    ctc_asid_va     = '0;
    ctc_va_pa       = '0;
    icache_inv_done = 1'b0;
    tlb_inv_done    = 1'b0;
    cr_ready        = 1'b0;
    flush_dis       = 1'b0;
    prev_strb       = '0;
    hold_done       = 1'b1;
    void'($urandom(32'hae64));
    $readmemh("ctcq_input.txt", stim_mem);
    for (int i = 0; i < NUM_REQ; i++)
    begin
      if ($isunknown(stim_mem[4*i+3]) || stim_mem[4*i] > 36'd5)
      begin
        errors++;
        $display("input file line %0d is missing or has an illegal opcode", i);
      end
      req_op[i]      = stim_mem[4*i][2:0];
      req_asid_va[i] = stim_mem[4*i+1][23:0];
      req_vapa[i]    = stim_mem[4*i+2];
      req_flush[i]   = stim_mem[4*i+3][0];
    end
    repeat (10) @(posedge ctcq_pe_clk);
    #2 cpurst_b = 1'b1;
    @(negedge ctcq_pe_clk);
    check_val(64'(strb), 64'(0), "strobes after reset");
    check_val(64'({cr_valid, ctc_flush_vld, ctcq_not_empty}), 64'(0), "outputs after reset");
    check_val(64'(create_rdy), 64'(1), "create_rdy after reset");
    while (xfer_cnt < NUM_REQ && !timed_out)
    begin
      @(posedge ctcq_pe_clk);
      #2;
      drive_cycle();
      @(negedge ctcq_pe_clk);
      check_cycle();
      cycles++;
      if (cycles >= MAX_CYC)
      begin
        timed_out = 1'b1;
        errors++;
        $display("timeout: %0d of %0d responses after %0d cycles", xfer_cnt, NUM_REQ, cycles);
      end
    end
    if (!timed_out)
    begin
      @(posedge ctcq_pe_clk);
      #2 cr_ready = 1'b0;
      @(negedge ctcq_pe_clk);
      check_val(64'(ctcq_not_empty), 64'(0), "ctcq_not_empty after drain");
      check_val(64'(create_rdy), 64'(1), "create_rdy after drain");
      check_val(64'(flush_cnt), 64'(flush_exp_cnt), "flush pulse count");
    end
    $display("errors %0d, requests %0d, transfers %0d", errors, NUM_REQ, xfer_cnt);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule
